//--- la_defs.svh
// shared widths, register map and credit setup of the logic analyzer
// register addresses are byte addresses in an 8-bit space, all 32-bit wide
// LA_CREDITS must fit in LA_CRW bits
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// probe and counter widths
`define LA_DW      8
`define LA_CW      16
`define LA_DCW     8
`define LA_RLE_CW  8

// output credits after reset, and the credit counter width
`define LA_CREDITS 4
`define LA_CRW     3

// register map
`define LA_A_CTL   8'h00
`define LA_A_PRE   8'h04
`define LA_A_PST   8'h08
`define LA_A_MSK   8'h0C
`define LA_A_VAL   8'h10
`define LA_A_EPOS  8'h14
`define LA_A_ENEG  8'h18
`define LA_A_DEC   8'h1C
`define LA_A_RLE   8'h20
`define LA_A_POL   8'h24
`define LA_A_DROP  8'h28

`endif

//--- la_pkg.sv
// types shared by the logic analyzer stages and the register port
// struct field order is fixed, the testbench packs and unpacks them
`include "la_defs.svh"

package la_pkg;

  // sample beat between the four stream stages, valid only
  typedef struct packed {
    logic              valid;
    logic              last;
    logic [`LA_DW-1:0] data;
  } smp_t;

  // output beat, count is run length minus one
  typedef struct packed {
    logic                  valid;
    logic                  last;
    logic [`LA_RLE_CW-1:0] count;
    logic [`LA_DW-1:0]     value;
  } out_t;

  // register access request, one cycle per access
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  // acquisition states, also read back in ctl bits 1:0
  typedef enum logic [1:0] {
    acq_idle  = 2'd0,
    acq_pre   = 2'd1,
    acq_armed = 2'd2,
    acq_post  = 2'd3
  } acq_state_e;

  // bit positions in the control register
  typedef enum logic [4:0] {
    ctl_bit_rst = 5'd0,
    ctl_bit_str = 5'd1,
    ctl_bit_stp = 5'd2,
    ctl_bit_trg = 5'd3
  } ctl_bit_e;

endpackage

//--- la_regs.sv
// register bank of the logic analyzer
// readback and ack arrive one cycle after the access, unmapped reads give 0
// ctl writes only create one-cycle pulses, nothing is stored there
`timescale 1ns/10ps
`include "la_defs.svh"

module la_regs import la_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  input  reg_req_t            req,
  output logic [31:0]         rdata,
  output logic                ack,
  output logic [`LA_CW-1:0]   cfg_pre,
  output logic [`LA_CW-1:0]   cfg_pst,
  output logic [`LA_DW-1:0]   cfg_msk,
  output logic [`LA_DW-1:0]   cfg_val,
  output logic [`LA_DW-1:0]   cfg_epos,
  output logic [`LA_DW-1:0]   cfg_eneg,
  output logic [`LA_DCW-1:0]  cfg_dec,
  output logic                cfg_rle,
  output logic [`LA_DW-1:0]   cfg_pol,
  output logic                evn_rst,
  output logic                evn_str,
  output logic                evn_stp,
  output logic                evn_trg,
  input  acq_state_e          sts_state,
  input  logic [`LA_CW-1:0]   drop_cnt
);

  logic ctl_wr;

  assign ctl_wr = req.wen && (req.addr == `LA_A_CTL);

  //////////////////////////////////////////////////////////////
  // handshake and control pulses
  //////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ack     <= 1'b0;
      evn_rst <= 1'b0;
      evn_str <= 1'b0;
      evn_stp <= 1'b0;
      evn_trg <= 1'b0;
    end else begin
      ack     <= req.wen || req.ren;
      // pulses last one cycle, low unless ctl is written
      evn_rst <= ctl_wr && req.wdata[ctl_bit_rst];
      evn_str <= ctl_wr && req.wdata[ctl_bit_str];
      evn_stp <= ctl_wr && req.wdata[ctl_bit_stp];
      evn_trg <= ctl_wr && req.wdata[ctl_bit_trg];
    end
  end

  //////////////////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg_pre  <= '0;
      cfg_pst  <= '0;
      cfg_msk  <= '0;
      cfg_val  <= '0;
      cfg_epos <= '0;
      cfg_eneg <= '0;
      cfg_dec  <= '0;
      cfg_rle  <= 1'b0;
      cfg_pol  <= '0;
    end else if (req.wen) begin
      case (req.addr)
        `LA_A_PRE:  cfg_pre  <= req.wdata[`LA_CW-1:0];
        `LA_A_PST:  cfg_pst  <= req.wdata[`LA_CW-1:0];
        `LA_A_MSK:  cfg_msk  <= req.wdata[`LA_DW-1:0];
        `LA_A_VAL:  cfg_val  <= req.wdata[`LA_DW-1:0];
        `LA_A_EPOS: cfg_epos <= req.wdata[`LA_DW-1:0];
        `LA_A_ENEG: cfg_eneg <= req.wdata[`LA_DW-1:0];
        `LA_A_DEC:  cfg_dec  <= req.wdata[`LA_DCW-1:0];
        `LA_A_RLE:  cfg_rle  <= req.wdata[0];
        `LA_A_POL:  cfg_pol  <= req.wdata[`LA_DW-1:0];
        default: ;
      endcase
    end
  end

  // readback, sampled every cycle, used by the host only with ack
  always_ff @(posedge bus) begin
    case (req.addr)
      `LA_A_CTL:  rdata <= {30'd0, sts_state};
      `LA_A_PRE:  rdata <= 32'(cfg_pre);
      `LA_A_PST:  rdata <= 32'(cfg_pst);
      `LA_A_MSK:  rdata <= 32'(cfg_msk);
      `LA_A_VAL:  rdata <= 32'(cfg_val);
      `LA_A_EPOS: rdata <= 32'(cfg_epos);
      `LA_A_ENEG: rdata <= 32'(cfg_eneg);
      `LA_A_DEC:  rdata <= 32'(cfg_dec);
      `LA_A_RLE:  rdata <= {31'd0, cfg_rle};
      `LA_A_POL:  rdata <= 32'(cfg_pol);
      `LA_A_DROP: rdata <= 32'(drop_cnt);
      default:    rdata <= '0;
    endcase
  end

endmodule

//--- la_dec.sv
// decimator, keeps one valid sample in every cfg_dec+1
// lowering cfg_dec below the running count wraps it on the next sample
`timescale 1ns/10ps
`include "la_defs.svh"

module la_dec import la_pkg::*; (
  input  logic               bus,
  input  logic               ctl_rst,
  input  logic               srst,
  input  logic [`LA_DCW-1:0] cfg_dec,
  input  smp_t               din,
  output smp_t               dout
);

  // samples seen since the last kept one
  logic [`LA_DCW-1:0] cnt;

  always_ff @(posedge bus) begin
    // payload follows the input, valid decides
    dout.data <= din.data;
    dout.last <= din.last;
    if (ctl_rst || srst) begin
      cnt        <= '0;
      dout.valid <= 1'b0;
    end else begin
      // only the sample at count zero passes
      dout.valid <= din.valid && (cnt == '0);
      if (din.valid) begin
        cnt <= (cnt >= cfg_dec) ? '0 : cnt + 1'b1;
      end
    end
  end

endmodule

//--- la_trigger.sv
// polarity and trigger stage, data and trg leave one cycle after the input
// level match needs a nonzero mask, edges compare with the previous valid sample
// no edge fires on the first sample after a reset
`timescale 1ns/10ps
`include "la_defs.svh"

module la_trigger import la_pkg::*; (
  input  logic              bus,
  input  logic              ctl_rst,
  input  logic              srst,
  input  logic [`LA_DW-1:0] cfg_pol,
  input  logic [`LA_DW-1:0] cfg_msk,
  input  logic [`LA_DW-1:0] cfg_val,
  input  logic [`LA_DW-1:0] cfg_epos,
  input  logic [`LA_DW-1:0] cfg_eneg,
  input  smp_t              din,
  output smp_t              dout,
  output logic              trg
);

  logic [`LA_DW-1:0] pol;
  logic [`LA_DW-1:0] prv;
  logic              prv_vld;
  logic              lvl;
  logic              edg;

  // inverted probe bits
  assign pol = din.data ^ cfg_pol;

  // comparator, masked equality
  assign lvl = (|cfg_msk) && ((pol & cfg_msk) == (cfg_val & cfg_msk));

  // rising bits in epos, falling bits in eneg
  assign edg = prv_vld && (|((pol & ~prv & cfg_epos) | (~pol & prv & cfg_eneg)));

  always_ff @(posedge bus) begin
    dout.data <= pol;
    dout.last <= din.last;
    // edge history
    if (din.valid) begin
      prv <= pol;
    end
    if (ctl_rst || srst) begin
      dout.valid <= 1'b0;
      trg        <= 1'b0;
      prv_vld    <= 1'b0;
    end else begin
      dout.valid <= din.valid;
      trg        <= din.valid && (lvl || edg);
      if (din.valid) begin
        prv_vld <= 1'b1;
      end
    end
  end

endmodule

//--- la_acq.sv
// acquisition FSM, forwards samples one cycle later while not idle
// cfg_pre samples before arming, cfg_pst samples after the trigger sample
// cfg_pst of 0 acts as 1, the post window always holds one sample
// stop wins over every other event and never produces last
`timescale 1ns/10ps
`include "la_defs.svh"

module la_acq import la_pkg::*; (
  input  logic              bus,
  input  logic              ctl_rst,
  input  logic              srst,
  input  logic              evn_str,
  input  logic              evn_stp,
  input  logic              evn_trg,
  input  logic              trg,
  input  logic [`LA_CW-1:0] cfg_pre,
  input  logic [`LA_CW-1:0] cfg_pst,
  input  smp_t              din,
  output smp_t              dout,
  output acq_state_e        state
);

  // window counter, one extra bit keeps the compare free of overflow
  logic [`LA_CW-1:0] cnt;
  logic [`LA_CW:0]   cnt_inc;
  logic              fin;

  assign cnt_inc = {1'b0, cnt} + 1'b1;

  // final post-trigger sample, carries last
  assign fin = (state == acq_post) && din.valid && !evn_stp &&
               (cnt_inc >= {1'b0, cfg_pst});

  //////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    dout.data <= din.data;
    if (ctl_rst || srst) begin
      dout.valid <= 1'b0;
      dout.last  <= 1'b0;
    end else begin
      // gate the stream to the active states
      dout.valid <= din.valid && (state != acq_idle);
      dout.last  <= fin;
    end
  end

  //////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst || srst) begin
      state <= acq_idle;
      cnt   <= '0;
    end else if (evn_stp) begin
      state <= acq_idle;
    end else begin
      case (state)
        acq_idle: begin
          if (evn_str) begin
            cnt   <= '0;
            // an empty pre window arms at once
            state <= (cfg_pre == '0) ? acq_armed : acq_pre;
          end
        end
        acq_pre: begin
          if (din.valid) begin
            if (cnt_inc >= {1'b0, cfg_pre}) begin
              cnt   <= '0;
              state <= acq_armed;
            end else begin
              cnt <= cnt_inc[`LA_CW-1:0];
            end
          end
        end
        acq_armed: begin
          // trigger sample itself still belongs to armed
          if (evn_trg || (din.valid && trg)) begin
            cnt   <= '0;
            state <= acq_post;
          end
        end
        acq_post: begin
          if (din.valid) begin
            cnt <= cnt_inc[`LA_CW-1:0];
            if (fin) begin
              state <= acq_idle;
            end
          end
        end
        default: state <= acq_idle;
      endcase
    end
  end

endmodule

//--- la_rle.sv
// run-length encoder with credit flow control on the output
// CW must not exceed LA_RLE_CW, the count field of out_t
// a beat that finds no credit is lost and counted in drop_cnt
// a last sample that also opens a new run leaves one cycle later
`timescale 1ns/10ps
`include "la_defs.svh"

module la_rle import la_pkg::*; #(
  parameter int unsigned CW = `LA_RLE_CW
) (
  input  logic              bus,
  input  logic              ctl_rst,
  input  logic              srst,
  input  logic              cfg_rle,
  input  smp_t              din,
  input  logic              crd,
  output out_t              dout,
  output logic [`LA_CW-1:0] drop_cnt
);

  // open run
  logic              run_vld;
  logic              run_lst;
  logic [CW-1:0]     run_cnt;
  logic [`LA_DW-1:0] run_val;
  // next run
  logic              rn_vld;
  logic              rn_lst;
  logic [CW-1:0]     rn_cnt;
  logic [`LA_DW-1:0] rn_val;
  // beat due this cycle
  logic              emit;
  logic              emit_ok;
  logic              e_lst;
  logic [CW-1:0]     e_cnt;
  logic [`LA_DW-1:0] e_val;
  logic [`LA_CRW-1:0] credits;

  //////////////////////////////////////////////////////////////
  // run tracking
  //////////////////////////////////////////////////////////////

  always_comb begin
    emit   = 1'b0;
    e_lst  = 1'b0;
    e_cnt  = '0;
    e_val  = din.data;
    rn_vld = run_vld;
    rn_lst = run_lst;
    rn_cnt = run_cnt;
    rn_val = run_val;
    if (!cfg_rle) begin
      // bypass, one beat per sample
      emit   = din.valid;
      e_lst  = din.last;
      rn_vld = 1'b0;
      rn_lst = 1'b0;
    end else if (run_vld && run_lst) begin
      // flush a pending last run
      emit   = 1'b1;
      e_lst  = 1'b1;
      e_cnt  = run_cnt;
      e_val  = run_val;
      rn_vld = din.valid;
      rn_lst = din.last;
      rn_cnt = '0;
      rn_val = din.data;
    end else if (din.valid) begin
      if (!run_vld) begin
        // single-sample last leaves at once
        emit   = din.last;
        e_lst  = din.last;
        rn_vld = !din.last;
        rn_lst = 1'b0;
        rn_cnt = '0;
        rn_val = din.data;
      end else if ((din.data == run_val) && !(&run_cnt)) begin
        if (din.last) begin
          emit   = 1'b1;
          e_lst  = 1'b1;
          e_cnt  = run_cnt + 1'b1;
          e_val  = run_val;
          rn_vld = 1'b0;
        end else begin
          rn_cnt = run_cnt + 1'b1;
        end
      end else begin
        // value change or full counter closes the run
        emit   = 1'b1;
        e_cnt  = run_cnt;
        e_val  = run_val;
        rn_vld = 1'b1;
        rn_lst = din.last;
        rn_cnt = '0;
        rn_val = din.data;
      end
    end
  end

  assign emit_ok = emit && (credits != '0);

  //////////////////////////////////////////////////////////////
  // output, credits and drops
  //////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    run_cnt    <= rn_cnt;
    run_val    <= rn_val;
    dout.last  <= e_lst;
    dout.count <= `LA_RLE_CW'(e_cnt);
    dout.value <= e_val;
    if (ctl_rst || srst) begin
      run_vld    <= 1'b0;
      run_lst    <= 1'b0;
      dout.valid <= 1'b0;
      credits    <= `LA_CRW'(`LA_CREDITS);
      drop_cnt   <= '0;
    end else begin
      run_vld    <= rn_vld;
      run_lst    <= rn_lst;
      dout.valid <= emit_ok;
      if (emit && !emit_ok) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
      // use and return in one cycle cancel out
      if (emit_ok && !crd) begin
        credits <= credits - 1'b1;
      end else if (!emit_ok && crd && (credits != `LA_CRW'(`LA_CREDITS))) begin
        credits <= credits + 1'b1;
      end
    end
  end

endmodule

//--- la_top.sv
// logic analyzer top, eight probe lines and one clock
// the probe source cannot stall, so beats without credit are dropped
// software reset clears the stream stages only, registers keep their values
`timescale 1ns/10ps
`include "la_defs.svh"

module la_top import la_pkg::*; (
  input  logic              bus,
  input  logic              ctl_rst,
  input  reg_req_t          req,
  output logic [31:0]       rdata,
  output logic              ack,
  input  logic [`LA_DW-1:0] probe,
  input  logic              probe_vld,
  input  logic              crd,
  output out_t              dout
);

  // configuration
  logic [`LA_CW-1:0]  cfg_pre;
  logic [`LA_CW-1:0]  cfg_pst;
  logic [`LA_DW-1:0]  cfg_msk;
  logic [`LA_DW-1:0]  cfg_val;
  logic [`LA_DW-1:0]  cfg_epos;
  logic [`LA_DW-1:0]  cfg_eneg;
  logic [`LA_DCW-1:0] cfg_dec;
  logic               cfg_rle;
  logic [`LA_DW-1:0]  cfg_pol;
  // events and status
  logic               evn_rst;
  logic               evn_str;
  logic               evn_stp;
  logic               evn_trg;
  logic               trg;
  acq_state_e         state;
  logic [`LA_CW-1:0]  drop_cnt;
  // stream between stages
  smp_t               smp_in;
  smp_t               smp_dec;
  smp_t               smp_trg;
  smp_t               smp_acq;

  assign smp_in = '{valid: probe_vld, last: 1'b0, data: probe};

  la_regs la_regs_inst (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .req       (req),
    .rdata     (rdata),
    .ack       (ack),
    .cfg_pre   (cfg_pre),
    .cfg_pst   (cfg_pst),
    .cfg_msk   (cfg_msk),
    .cfg_val   (cfg_val),
    .cfg_epos  (cfg_epos),
    .cfg_eneg  (cfg_eneg),
    .cfg_dec   (cfg_dec),
    .cfg_rle   (cfg_rle),
    .cfg_pol   (cfg_pol),
    .evn_rst   (evn_rst),
    .evn_str   (evn_str),
    .evn_stp   (evn_stp),
    .evn_trg   (evn_trg),
    .sts_state (state),
    .drop_cnt  (drop_cnt)
  );

  ////////////////////////////////////////////////////////////
  // sample path
  ////////////////////////////////////////////////////////////

  la_dec la_dec_inst (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .srst    (evn_rst),
    .cfg_dec (cfg_dec),
    .din     (smp_in),
    .dout    (smp_dec)
  );

  la_trigger la_trigger_inst (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .srst     (evn_rst),
    .cfg_pol  (cfg_pol),
    .cfg_msk  (cfg_msk),
    .cfg_val  (cfg_val),
    .cfg_epos (cfg_epos),
    .cfg_eneg (cfg_eneg),
    .din      (smp_dec),
    .dout     (smp_trg),
    .trg      (trg)
  );

  la_acq la_acq_inst (
    .bus     (bus),
    .ctl_rst (ctl_rst),
    .srst    (evn_rst),
    .evn_str (evn_str),
    .evn_stp (evn_stp),
    .evn_trg (evn_trg),
    .trg     (trg),
    .cfg_pre (cfg_pre),
    .cfg_pst (cfg_pst),
    .din     (smp_trg),
    .dout    (smp_acq),
    .state   (state)
  );

  la_rle #(
    .CW (`LA_RLE_CW)
  ) la_rle_inst (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .srst     (evn_rst),
    .cfg_rle  (cfg_rle),
    .din      (smp_acq),
    .crd      (crd),
    .dout     (dout),
    .drop_cnt (drop_cnt)
  );

endmodule

//--- la_checker.sv
// assertions bound into la_rle and la_acq
// unused inputs of a binding are tied to values that keep their checks quiet
`timescale 1ns/10ps
`include "la_defs.svh"

module la_checker (
  input logic               bus,
  input logic               ctl_rst,
  input logic [`LA_CRW-1:0] credits,
  input logic               out_vld,
  input logic               last_vld,
  input logic               in_post
);

  // no beat leaves while the credit count is empty
  a_crd_use: assert property (@(posedge bus) disable iff (ctl_rst)
    (credits == '0) |=> !out_vld)
    else $error("output beat emitted with zero credits");

  // returned credits saturate
  a_crd_max: assert property (@(posedge bus) disable iff (ctl_rst)
    credits <= `LA_CREDITS)
    else $error("credit count above the reset value");

  // last only from the post window
  a_last_post: assert property (@(posedge bus) disable iff (ctl_rst)
    !in_post |=> !last_vld)
    else $error("last beat outside the post state");

endmodule

//--- la_tb.sv
// testbench for la_top with rows of a stimulus table applied in order
// probe patterns are driven after the start pulse so no sample meets idle
// each row ends with a software reset that config registers must survive
// expected beats come from a behavioral model of the sample path
`timescale 1ns/10ps
`include "la_defs.svh"

module la_tb import la_pkg::*; ();

  // one test row with pattern kind 0 counting, 1 random runs or 2 random samples
  typedef struct {
    string               name;
    logic [`LA_CW-1:0]   pre;
    logic [`LA_CW-1:0]   pst;
    logic [`LA_DW-1:0]   msk;
    logic [`LA_DW-1:0]   val;
    logic [`LA_DW-1:0]   epos;
    logic [`LA_DW-1:0]   eneg;
    logic [`LA_DCW-1:0]  dec;
    logic                rle;
    logic [`LA_DW-1:0]   pol;
    int                  kind;
    int                  len;
    logic                crd_on;
    logic                stop;
  } row_t;

  localparam int run_max = (1 << `LA_RLE_CW) - 1;

  logic              bus;
  logic              ctl_rst;
  reg_req_t          req;
  logic [31:0]       rdata;
  logic              ack;
  logic [`LA_DW-1:0] probe;
  logic              probe_vld;
  logic              crd;
  out_t              dout;

  row_t              rows [6];
  logic [7:0]        pat [$];
  // beats as {last, count, value}
  logic [16:0]       exp_q [$];
  logic [16:0]       got_q [$];
  int                exp_drop;
  logic              exp_idle;
  logic              crd_on;
  int                errors;
  int                wd_cycles;

  la_top la_top_inst (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .req       (req),
    .rdata     (rdata),
    .ack       (ack),
    .probe     (probe),
    .probe_vld (probe_vld),
    .crd       (crd),
    .dout      (dout)
  );

  // credit checks on the encoder and last legality on the FSM
  bind la_rle la_checker rle_chk (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .credits  (credits),
    .out_vld  (dout.valid),
    .last_vld (1'b0),
    .in_post  (1'b1)
  );
  bind la_acq la_checker acq_chk (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .credits  (`LA_CRW'(`LA_CREDITS)),
    .out_vld  (1'b0),
    .last_vld (dout.last),
    .in_post  (state == acq_post)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  // collect beats and return one credit per beat when enabled
  always @(posedge bus) begin
    #1;
    if (dout.valid) begin
      got_q.push_back({dout.last, dout.count, dout.value});
    end
    #1;
    crd = crd_on && dout.valid;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge bus);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge bus);
    #2;
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expv, input logic [31:0] act);
    errors++;
    $display("error %s %s: expected %0h actual %0h", test, what, expv, act);
  endtask

  // one register access with ack and rdata due one cycle later
  task automatic bus_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wd, output logic [31:0] rd);
    req = '{wen: wr, ren: !wr, addr: addr, wdata: wd};
    step();
    req = '0;
    if (!ack) begin
      errors++;
      $display("no ack one cycle after the access to address %h", addr);
    end
    rd = rdata;
  endtask

  // write the row config or read it back and compare
  task automatic cfg_regs(input row_t rw, input logic wr);
    logic [7:0]  adr [9];
    logic [31:0] val [9];
    logic [31:0] rd;
    adr = '{`LA_A_PRE, `LA_A_PST, `LA_A_MSK, `LA_A_VAL, `LA_A_EPOS, `LA_A_ENEG,
            `LA_A_DEC, `LA_A_RLE, `LA_A_POL};
    val = '{32'(rw.pre), 32'(rw.pst), 32'(rw.msk), 32'(rw.val), 32'(rw.epos),
            32'(rw.eneg), 32'(rw.dec), 32'(rw.rle), 32'(rw.pol)};
    foreach (adr[j]) begin
      bus_access(wr, adr[j], val[j], rd);
      if (!wr && rd !== val[j]) begin
        report_mismatch(rw.name, $sformatf("readback at %h", adr[j]), val[j], rd);
      end
    end
  endtask

  task automatic build_pattern(input row_t rw);
    logic [7:0] v;
    int         n;
    logic       long_done;
    pat.delete();
    long_done = 1'b0;
    if (rw.kind == 1) begin
      // random runs with one of 300 to split the run counter
      while (pat.size() < rw.len - 8) begin
        v = 8'($urandom) & 8'h7f;
        n = (!long_done && pat.size() >= 10) ? 300 : 1 + $urandom % 6;
        long_done = long_done || (n == 300);
        repeat (n) begin
          if (pat.size() < rw.len - 8) pat.push_back(v);
        end
      end
      // closing ff run whose bit 7 hits the comparator
      while (pat.size() < rw.len) pat.push_back(8'hff);
    end else begin
      for (int i = 0; i < rw.len; i++) begin
        pat.push_back((rw.kind == 0) ? 8'(i) : 8'($urandom));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic predict(input row_t rw);
    logic [7:0] smp_q [$];
    logic       lst_q [$];
    logic [7:0] p;
    logic [7:0] prv;
    logic [7:0] run_v;
    logic       trg;
    logic       done;
    int         phase;
    int         n;
    int         run_n;
    int         limit;
    exp_q.delete();
    prv   = '0;
    run_v = '0;
    done  = 1'b0;
    n     = 0;
    // phase 0 is pre, 1 armed and 2 post
    phase = (rw.pre == 0) ? 1 : 0;
    limit = (rw.pst == 0) ? 1 : int'(rw.pst);
    for (int i = 0; i < pat.size(); i += int'(rw.dec) + 1) begin
      p   = pat[i] ^ rw.pol;
      trg = ((rw.msk != 0) && ((p & rw.msk) == (rw.val & rw.msk))) ||
            ((i != 0) && (|((p & ~prv & rw.epos) | (~p & prv & rw.eneg))));
      prv = p;
      if (!done) begin
        smp_q.push_back(p);
        lst_q.push_back(1'b0);
        if (phase == 0) begin
          n++;
          if (n >= rw.pre) phase = 1;
        end else if (phase == 1) begin
          if (trg) begin
            phase = 2;
            n     = 0;
          end
        end else begin
          n++;
          if (n >= limit) begin
            lst_q[$] = 1'b1;
            done     = 1'b1;
          end
        end
      end
    end
    // an open run without last stays inside the encoder
    run_n = -1;
    foreach (smp_q[k]) begin
      if (!rw.rle) begin
        exp_q.push_back({lst_q[k], 8'd0, smp_q[k]});
      end else if (run_n >= 0 && smp_q[k] == run_v && run_n < run_max) begin
        run_n++;
        if (lst_q[k]) begin
          exp_q.push_back({1'b1, 8'(run_n), run_v});
          run_n = -1;
        end
      end else begin
        if (run_n >= 0) exp_q.push_back({1'b0, 8'(run_n), run_v});
        run_v = smp_q[k];
        run_n = 0;
        if (lst_q[k]) begin
          exp_q.push_back({1'b1, 8'd0, run_v});
          run_n = -1;
        end
      end
    end
    // without credit return only the reset credits get out
    exp_drop = 0;
    while (!rw.crd_on && exp_q.size() > `LA_CREDITS) begin
      void'(exp_q.pop_back());
      exp_drop++;
    end
    exp_idle = done || rw.stop;
  endtask

  ////////////////////////////////////////////////////////////
  // one row
  ////////////////////////////////////////////////////////////

  task automatic run_row(input row_t rw);
    logic [31:0] rd;
    int          n;
    build_pattern(rw);
    predict(rw);
    cfg_regs(rw, 1'b1);
    cfg_regs(rw, 1'b0);
    got_q.delete();
    crd_on = rw.crd_on;
    bus_access(1'b1, `LA_A_CTL, 32'(1 << ctl_bit_str), rd);
    step();
    step();
    foreach (pat[i]) begin
      probe     = pat[i];
      probe_vld = 1'b1;
      step();
    end
    probe_vld = 1'b0;
    if (rw.stop) begin
      bus_access(1'b0, `LA_A_CTL, '0, rd);
      if (rd[1:0] !== acq_armed) report_mismatch(rw.name, "state before stop", acq_armed, rd);
      bus_access(1'b1, `LA_A_CTL, 32'(1 << ctl_bit_stp), rd);
    end
    // wait for the expected beats, then look for extra ones
    n = 0;
    while (got_q.size() < exp_q.size() && n < 200) begin
      step();
      n++;
    end
    if (got_q.size() < exp_q.size()) begin
      errors++;
      $display("%s: output beats stopped arriving before the expected count", rw.name);
    end
    repeat (8) step();
    if (got_q.size() != exp_q.size()) begin
      report_mismatch(rw.name, "beat count", exp_q.size(), got_q.size());
    end
    foreach (exp_q[k]) begin
      if (k < got_q.size() && got_q[k] !== exp_q[k]) begin
        report_mismatch(rw.name, $sformatf("beat %0d", k), exp_q[k], got_q[k]);
      end
    end
    if (exp_idle) begin
      bus_access(1'b0, `LA_A_CTL, '0, rd);
      if (rd[1:0] !== acq_idle) report_mismatch(rw.name, "final state", acq_idle, rd);
    end
    bus_access(1'b0, `LA_A_DROP, '0, rd);
    if (rd !== 32'(exp_drop)) report_mismatch(rw.name, "drop count", exp_drop, rd);
    // software reset clears the stream state and keeps the config
    bus_access(1'b1, `LA_A_CTL, 32'(1 << ctl_bit_rst), rd);
    step();
    if (la_top_inst.la_rle_inst.credits !== `LA_CRW'(`LA_CREDITS)) begin
      report_mismatch(rw.name, "credits after reset", `LA_CREDITS,
                      la_top_inst.la_rle_inst.credits);
    end
    bus_access(1'b0, `LA_A_DROP, '0, rd);
    if (rd !== '0) report_mismatch(rw.name, "drop count after reset", 0, rd);
    cfg_regs(rw, 1'b0);
  endtask

  // columns are name, pre, pst, msk, val, epos, eneg, dec, rle, pol, kind, len, crd, stop
  task automatic fill_rows();
    rows[0] = '{"decimate", 16'd1000, 16'd0, 8'h00, 8'h00, 8'h00, 8'h00,
                8'd2, 1'b0, 8'ha5, 0, 30, 1'b1, 1'b0};
    rows[1] = '{"level_trigger", 16'd3, 16'd4, 8'hf0, 8'h30, 8'h00, 8'h00,
                8'd0, 1'b0, 8'h00, 0, 80, 1'b1, 1'b0};
    rows[2] = '{"edge_trigger", 16'd2, 16'd3, 8'h00, 8'h00, 8'h20, 8'h08,
                8'd1, 1'b0, 8'h01, 0, 60, 1'b1, 1'b0};
    rows[3] = '{"rle_runs", 16'd0, 16'd3, 8'h80, 8'h80, 8'h00, 8'h00,
                8'd0, 1'b1, 8'h00, 1, 400, 1'b1, 1'b0};
    rows[4] = '{"no_credit", 16'd1000, 16'd0, 8'h00, 8'h00, 8'h00, 8'h00,
                8'd0, 1'b0, 8'h00, 0, 20, 1'b0, 1'b0};
    rows[5] = '{"stop_armed", 16'd2, 16'd5, 8'h00, 8'h00, 8'h00, 8'h00,
                8'd0, 1'b0, 8'h3c, 2, 25, 1'b1, 1'b1};
  endtask

  initial begin
    int budget;
    ctl_rst   = 1'b1;
    req       = '0;
    probe     = '0;
    probe_vld = 1'b0;
    crd       = 1'b0;
    crd_on    = 1'b0;
    errors    = 0;
    wd_cycles = 0;
    void'($urandom(64126));
    fill_rows();
    // watchdog budget from the pattern lengths
    budget = 200;
    foreach (rows[r]) budget += rows[r].len * 4;
    wd_cycles = budget;
    repeat (5) @(posedge bus);
    #2;
    ctl_rst = 1'b0;
    foreach (rows[r]) run_row(rows[r]);
    $display("la_tb done: %0d rows, %0d errors", $size(rows), errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
la_pkg.sv
la_regs.sv
la_dec.sv
la_trigger.sv
la_acq.sv
la_rle.sv
la_top.sv
la_checker.sv
la_tb.sv
